/* Makefile */
TOP = tbControlUnit

sim:
	verilator --binary --assert --timescale 1ns/100ps -f project.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
		echo "$$out" | grep -q "^Test completed successfully$$"

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* controlDecoder.sv */
// Combinational decode of phase, sub-cycle and instruction into datapath and memory controls
`timescale 1ns/100ps
`default_nettype none

module controlDecoder import controlPkg::*; (
	input  logic     Clock,
	input  logic     nReset,
	input  phaseT    phase,
	input  subCycleT subCycle,
	input  opcodeT   opcode,
	input  branchT   branchCode,
	input  logic     branchTaken,
	output logic     ALE,
	output logic     nME,
	output logic     nOE,
	output logic     nWE,
	output logic     MemEn,
	output logic     ENB,
	output logic     AluEn,
	output logic     AluWe,
	output logic     PcEn,
	output logic     PcWe,
	output logic     IrWe,
	output logic     RegWe,
	output logic     LrEn,
	output logic     LrWe,
	output op1SelT   Op1Sel,
	output op2SelT   Op2Sel,
	output rs1SelT   Rs1Sel,
	output wdSelT    WdSel,
	output immSelT   ImmSel,
	output lrSelT    LrSel,
	output pcSelT    PcSel,
	output logic     statusWe,
	output logic     longOp
);

	assign longOp = opcode inside {LDW, STW};

	always_comb begin
		ALE = 1'b0;
		nME = 1'b1;
		nOE = 1'b0;
		nWE = 1'b0;
		MemEn = 1'b0;
		ENB = 1'b0;
		AluEn = 1'b0;
		AluWe = 1'b0;
		PcEn = 1'b0;
		PcWe = 1'b0;
		IrWe = 1'b0;
		RegWe = 1'b0;
		LrEn = 1'b0;
		LrWe = 1'b0;
		Op1Sel = Op1Rd1;
		Op2Sel = Op2Imm;
		Rs1Sel = Rs1Ra;
		WdSel = WdAlu;
		ImmSel = ImmLong;
		LrSel = LrSys;
		PcSel = Pc1;
		statusWe = 1'b0;
		if (phase == Fetch) begin
			case (subCycle)
				Cycle0: begin
					ALE = 1'b1; // PC out as address
					nOE = 1'b1;
					nWE = 1'b1;
					PcEn = 1'b1;
				end
				Cycle1: begin
					nME = 1'b0;
					nWE = 1'b1;
					MemEn = 1'b1;
				end
				Cycle2: begin
					nME = 1'b0;
					nWE = 1'b1;
					MemEn = 1'b1;
					ENB = 1'b1;
				end
				Cycle3: begin
					nWE = 1'b1;
					MemEn = 1'b1;
					IrWe = 1'b1;
				end
				default: ;
			endcase
		end else if (phase == Execute) begin
			case (subCycle)
				Cycle0:
					case (opcode)
						LDW, STW: begin
							AluEn = 1'b1; // Effective address
							AluWe = 1'b1;
							ImmSel = ImmShort;
						end
						LUI, LLI: begin
							AluEn = 1'b1;
							RegWe = 1'b1;
							PcWe = 1'b1;
							Rs1Sel = Rs1Rd;
						end
						BRANCH:
							case (branchCode)
								JMP: begin
									ImmSel = ImmShort;
									PcSel = PcAluOut;
									PcWe = 1'b1;
								end
								RET: begin
									LrEn = 1'b1; // Link register onto bus
									PcSel = PcSysbus;
									PcWe = 1'b1;
								end
								default: begin
									PcWe = 1'b1;
									Op1Sel = Op1Pc; // PC relative
									AluEn = 1'b1;
									if (branchTaken) begin
										PcSel = PcAluOut;
										if (branchCode == BWL) begin
											LrWe = 1'b1;
											LrSel = LrPc;
										end
									end
								end
							endcase
						default: begin
							PcEn = 1'b1;
							PcWe = 1'b1;
							statusWe = 1'b1;
							RegWe = !(opcode inside {CMP, CMPI}); // Compare only sets flags
							if (opcode inside {ADD, SUB, CMP, AND, OR, XOR, NAND, NOR})
								Op2Sel = Op2Rd2;
							if (opcode inside {ADDI, SUBI, CMPI, LSL, LSR, ASR})
								ImmSel = ImmShort;
							if (opcode inside {ADDIB, SUBIB})
								Rs1Sel = Rs1Rd;
						end
					endcase
				Cycle1:
					if (longOp) begin
						ALE = 1'b1; // Data address out
						nOE = 1'b1;
						nWE = 1'b1;
						ImmSel = ImmShort;
						AluEn = 1'b1;
					end
				Cycle2:
					if (longOp) begin
						nME = 1'b0;
						nOE = 1'b1;
						nWE = 1'b1;
						MemEn = opcode == LDW;
						Op2Sel = Op2Zero;
						Rs1Sel = Rs1Rd; // Store data passes through ALU
						AluWe = 1'b1;
						AluEn = 1'b1;
					end
				Cycle3:
					if (opcode == LDW) begin
						nME = 1'b0;
						nWE = 1'b1;
						MemEn = 1'b1;
						ENB = 1'b1;
					end else if (opcode == STW) begin
						nME = 1'b0;
						nOE = 1'b1;
						AluEn = 1'b1; // Hold store data
						Op2Sel = Op2Zero;
					end
				Cycle4:
					if (opcode == LDW) begin
						PcWe = 1'b1;
						nWE = 1'b1;
						MemEn = 1'b1;
						WdSel = WdSys;
						RegWe = 1'b1;
					end else if (opcode == STW) begin
						PcWe = 1'b1;
						nOE = 1'b1;
						AluEn = 1'b1;
						Op2Sel = Op2Zero;
					end
				default: ;
			endcase
		end
	end

	aleNotDuringAccess: assert property (@(posedge Clock) disable iff (!nReset)
		!(ALE && !nME));

endmodule

`default_nettype wire

/* controlGolden.txt */
# name flags(hex) opcodeCond(hex) waits pcSel regWe period
# pcSel 0 Pc1, 1 PcAluOut, 2 PcSysbus; period in cycles including waits
add 0 00 0 0 1 5
addWait 2 00 2 0 1 7
sub 3 28 1 0 1 6
andOp 8 68 0 0 1 5
adc 2 18 0 0 1 5
lui 0 b0 0 0 1 5
cmpZero 1 58 0 0 0 5
cmpNonZero 2 58 3 0 0 8
beTaken 1 d5 0 1 0 5
beSkipped 0 d5 0 0 0 5
bneTaken 0 d4 1 1 0 6
bneSkipped 1 d4 0 0 0 5
bltNV00 0 d6 0 0 0 5
bltNV01 4 d6 0 1 0 5
bltNV10 8 d6 0 1 0 5
bltNV11 c d6 0 0 0 5
bgeNV00 0 d7 0 1 0 5
bgeNV01 4 d7 0 0 0 5
bgeNV10 8 d7 0 0 0 5
bgeNV11 c d7 2 1 0 7
br 0 d0 0 1 0 5
bwl 5 d3 0 1 0 5
bwlWait e d3 1 1 0 6
jmp 0 d1 0 1 0 5
ret 0 d2 0 2 0 5
ldw 0 c0 0 0 1 9
ldwWait 2 c0 3 0 1 12
ldwWaitLong 1 c0 4 0 1 13
stw 0 c8 0 0 0 9
stwWait 2 c8 2 0 0 11

/* controlPkg.sv */
// Opcode, branch, flag, sequencing and select types shared by the control unit RTL and testbench
`default_nettype none

package controlPkg;

	typedef enum logic [4:0] {
		ADD,
		ADDI,
		ADDIB,
		ADC,
		ADCI,
		SUB,
		SUBI,
		SUBIB,
		SUC,
		SUCI,
		NEG,
		CMP,
		CMPI,
		AND,
		OR,
		XOR,
		NAND,
		NOR,
		NOT,
		LSL,
		LSR,
		ASR,
		LUI,
		LLI,
		LDW,
		STW,
		BRANCH
	} opcodeT;

	typedef enum logic [2:0] {
		BR  = 3'd0,
		JMP = 3'd1,
		RET = 3'd2,
		BWL = 3'd3,
		BNE = 3'd4,
		BE  = 3'd5,
		BLT = 3'd6,
		BGE = 3'd7
	} branchT;

	typedef logic [3:0] flagsT;

	localparam int flagZ = 0;
	localparam int flagC = 1;
	localparam int flagV = 2;
	localparam int flagN = 3;

	typedef enum logic [1:0] {Fetch, Execute} phaseT;
	typedef enum logic [2:0] {Cycle0, Cycle1, Cycle2, Cycle3, Cycle4} subCycleT;

	typedef enum logic {Op1Rd1, Op1Pc} op1SelT;
	typedef enum logic [1:0] {Op2Imm, Op2Rd2, Op2Zero} op2SelT;
	typedef enum logic {Rs1Ra, Rs1Rd} rs1SelT;
	typedef enum logic {WdAlu, WdSys} wdSelT;
	typedef enum logic {ImmLong, ImmShort} immSelT;
	typedef enum logic {LrSys, LrPc} lrSelT;
	typedef enum logic [1:0] {Pc1, PcAluOut, PcSysbus} pcSelT;

endpackage

`default_nettype wire

/* controlSequencer.sv */
// Fetch and execute phase FSM with sub-cycle counting and nWait holds
`timescale 1ns/100ps
`default_nettype none

module controlSequencer import controlPkg::*; (
	input  logic     Clock,
	input  logic     nReset,
	input  logic     nWait,
	input  logic     longOp,
	output phaseT    phase,
	output subCycleT subCycle
);

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			phase <= Fetch;
			subCycle <= Cycle0;
		end else begin
			case (phase)
				Fetch:
					case (subCycle)
						Cycle0:
							subCycle <= Cycle1;
						Cycle1:
							subCycle <= Cycle2;
						Cycle2:
							if (nWait)
								subCycle <= Cycle3; // Instruction read wait
						Cycle3: begin
							phase <= Execute;
							subCycle <= Cycle0;
						end
						default:
							subCycle <= Cycle0;
					endcase
				Execute:
					case (subCycle)
						Cycle0:
							if (longOp)
								subCycle <= Cycle1;
							else
								phase <= Fetch; // Single cycle ops
						Cycle1:
							subCycle <= Cycle2;
						Cycle2:
							subCycle <= Cycle3;
						Cycle3:
							if (nWait)
								subCycle <= Cycle4; // Data access wait
						default: begin
							phase <= Fetch;
							subCycle <= Cycle0;
						end
					endcase
				default: begin
					phase <= Fetch;
					subCycle <= Cycle0;
				end
			endcase
		end
	end

	fetchNoCycle4: assert property (@(posedge Clock) disable iff (!nReset)
		phase == Fetch |-> subCycle != Cycle4);

endmodule

`default_nettype wire

/* controlUnit.sv */
// Top level of the control unit joining status register, sequencer and decoder
`timescale 1ns/100ps
`default_nettype none

module controlUnit import controlPkg::*; (
	input  logic       Clock,
	input  logic       nReset,
	input  logic [7:0] opcodeCond,
	input  flagsT      flags,
	input  logic       nWait,
	output logic       ALE,
	output logic       nME,
	output logic       nOE,
	output logic       nWE,
	output logic       MemEn,
	output logic       ENB,
	output logic       AluEn,
	output logic       AluWe,
	output logic       PcEn,
	output logic       PcWe,
	output logic       IrWe,
	output logic       RegWe,
	output logic       LrEn,
	output logic       LrWe,
	output op1SelT     Op1Sel,
	output op2SelT     Op2Sel,
	output rs1SelT     Rs1Sel,
	output wdSelT      WdSel,
	output immSelT     ImmSel,
	output lrSelT      LrSel,
	output pcSelT      PcSel,
	output logic       CFlag
);

	opcodeT   opcode;
	branchT   branchCode;
	phaseT    phase;
	subCycleT subCycle;
	logic     longOp;
	logic     statusWe;
	logic     branchTaken;

	assign opcode = opcodeT'(opcodeCond[7:3]);
	assign branchCode = branchT'(opcodeCond[2:0]); // Condition field

	statusRegister statusReg (.*);

	controlSequencer sequencer (.*);

	controlDecoder decoder (.*);

endmodule

`default_nettype wire

/* project.f */
controlPkg.sv
statusRegister.sv
controlSequencer.sv
controlDecoder.sv
controlUnit.sv
tbControlUnit.sv

/* statusRegister.sv */
// Four-bit status register loaded from the ALU flags, with branch condition evaluation
`timescale 1ns/100ps
`default_nettype none

module statusRegister import controlPkg::*; (
	input  logic   Clock,
	input  logic   nReset,
	input  logic   statusWe,
	input  flagsT  flags,
	input  branchT branchCode,
	output logic   branchTaken,
	output logic   CFlag
);

	flagsT status;

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset)
			status <= '0;
		else if (statusWe)
			status <= flags;
	end

	always_comb begin
		case (branchCode)
			BR, BWL:
				branchTaken = 1'b1; // Unconditional
			BNE:
				branchTaken = !status[flagZ];
			BE:
				branchTaken = status[flagZ];
			BLT:
				branchTaken = status[flagN] != status[flagV]; // Signed less than
			BGE:
				branchTaken = status[flagN] == status[flagV];
			default:
				branchTaken = 1'b0; // JMP and RET decoded directly
		endcase
	end

	assign CFlag = status[flagC];

endmodule

`default_nettype wire

/* tbControlUnit.sv */
// Testbench for the control unit, run from the test lines of controlGolden.txt
`timescale 1ns/100ps
`default_nettype none

module tbControlUnit import controlPkg::*; ();

	logic Clock = 1'b0;
	logic nReset;
	logic [7:0] opcodeCond;
	flagsT flags;
	logic nWait;
	logic ALE, nME, nOE, nWE, MemEn, ENB;
	logic AluEn, AluWe, PcEn, PcWe, IrWe, RegWe, LrEn, LrWe, CFlag;
	op1SelT Op1Sel;
	op2SelT Op2Sel;
	rs1SelT Rs1Sel;
	wdSelT WdSel;
	immSelT ImmSel;
	lrSelT LrSel;
	pcSelT PcSel;

	string testName[$];
	flagsT testFlags[$];
	logic [7:0] testCode[$];
	int testWaits[$];
	pcSelT expPcSel[$];
	logic expRegWe[$];
	int expPeriod[$];

	integer seed = 32'h37d7;
	int timeLimit = 0;
	pcSelT seenPcSel; // PcSel in execute Cycle0
	logic lastRegWe;
	logic earlyRegWe;
	logic lastWdSys;
	logic seenLrWe;
	lrSelT seenLrSel;
	logic seenLrEn;
	int period;
	int irWeCount;

	controlUnit uut (.*);

	always #5 Clock = ~Clock;

	task automatic reportFailure(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkPcSel(input string test, input pcSelT expected, input pcSelT actual);
		if (actual !== expected)
			reportFailure($sformatf("MISMATCH %s PcSel expected %s actual %s",
				test, expected.name(), actual.name()));
	endtask

	task automatic checkOp2Sel(input string test, input op2SelT expected, input op2SelT actual);
		if (actual !== expected)
			reportFailure($sformatf("MISMATCH %s Op2Sel expected %s actual %s",
				test, expected.name(), actual.name()));
	endtask

	task automatic checkBit(input string test, input string what, input logic expected,
			input logic actual);
		if (actual !== expected)
			reportFailure($sformatf("MISMATCH %s %s expected %b actual %b",
				test, what, expected, actual));
	endtask

	task automatic checkCount(input string test, input string what, input int expected,
			input int actual);
		if (actual != expected)
			reportFailure($sformatf("MISMATCH %s %s expected %0d actual %0d",
				test, what, expected, actual));
	endtask

	task automatic loadGolden();
		int fd;
		int fields;
		string line;
		string name;
		logic [3:0] fl;
		logic [7:0] code;
		int waits;
		logic [1:0] pcSel;
		logic regWe;
		int cycles;
		fd = $fopen("controlGolden.txt", "r");
		if (fd == 0)
			reportFailure("could not open controlGolden.txt");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line[0] == "#")
				continue; // Header or blank
			fields = $sscanf(line, "%s %h %h %d %d %d %d",
				name, fl, code, waits, pcSel, regWe, cycles);
			if (fields != 7)
				reportFailure({"malformed golden line: ", line});
			testName.push_back(name);
			testFlags.push_back(fl);
			testCode.push_back(code);
			testWaits.push_back(waits);
			expPcSel.push_back(pcSelT'(pcSel));
			expRegWe.push_back(regWe);
			expPeriod.push_back(cycles);
		end
		$fclose(fd);
	endtask

	// Entered and left at the falling edge inside Fetch Cycle0
	task automatic runInstruction(input logic [7:0] code, input int waits);
		int fetchWaits;
		int execWaits;
		int execIdx;
		logic irWeLast;
		logic isLong;
		isLong = code[7:3] inside {LDW, STW};
		fetchWaits = isLong ? {$random(seed)} % (waits + 1) : waits; // Split over both slots
		execWaits = waits - fetchWaits;
		opcodeCond = code;
		nWait = 1'b1;
		period = 1;
		execIdx = -1;
		irWeLast = 1'b0;
		irWeCount = 0;
		seenPcSel = Pc1;
		lastRegWe = RegWe;
		earlyRegWe = 1'b0;
		lastWdSys = 1'b0;
		seenLrWe = 1'b0;
		seenLrSel = LrSys;
		seenLrEn = 1'b0;
		forever begin
			@(negedge Clock);
			if (ALE && PcEn)
				break; // Next fetch
			period++;
			if (execIdx >= 0 && nWait)
				execIdx++;
			else if (irWeLast)
				execIdx = 0;
			irWeLast = IrWe;
			if (IrWe)
				irWeCount++;
			if (execIdx == 0)
				seenPcSel = PcSel;
			earlyRegWe |= lastRegWe;
			lastRegWe = RegWe;
			lastWdSys = WdSel == WdSys;
			seenLrWe |= LrWe;
			if (LrWe)
				seenLrSel = LrSel;
			seenLrEn |= LrEn;
			nWait = 1'b1;
			if (execIdx < 0 && period >= 3 && !IrWe && fetchWaits > 0) begin
				nWait = 1'b0; // Fetch Cycle2
				fetchWaits--;
			end
			if (execIdx == 3 && execWaits > 0) begin
				nWait = 1'b0; // Data access slot
				execWaits--;
			end
		end
	endtask

	initial begin
		wait (timeLimit > 0);
		#(timeLimit);
		reportFailure($sformatf("timeout after %0d ns without finishing the tests", timeLimit));
	end

	initial begin
		nReset = 1'b0;
		opcodeCond = '0;
		flags = '0;
		nWait = 1'b1;
		loadGolden();
		timeLimit = (testName.size() * 20 + 10) * 10;
		repeat (5) @(negedge Clock);
		checkBit("reset", "ALE", 1'b1, ALE);
		checkBit("reset", "nME", 1'b1, nME);
		checkBit("reset", "nOE", 1'b1, nOE);
		checkBit("reset", "nWE", 1'b1, nWE);
		checkBit("reset", "PcEn", 1'b1, PcEn);
		checkBit("reset", "MemEn", 1'b0, MemEn);
		checkBit("reset", "ENB", 1'b0, ENB);
		checkBit("reset", "AluEn", 1'b0, AluEn);
		checkBit("reset", "AluWe", 1'b0, AluWe);
		checkBit("reset", "IrWe", 1'b0, IrWe);
		checkBit("reset", "RegWe", 1'b0, RegWe);
		checkBit("reset", "PcWe", 1'b0, PcWe);
		checkBit("reset", "LrEn", 1'b0, LrEn);
		checkBit("reset", "LrWe", 1'b0, LrWe);
		checkBit("reset", "Op1Sel", Op1Rd1, Op1Sel);
		checkOp2Sel("reset", Op2Imm, Op2Sel);
		checkBit("reset", "Rs1Sel", Rs1Ra, Rs1Sel);
		checkBit("reset", "WdSel", WdAlu, WdSel);
		checkBit("reset", "ImmSel", ImmLong, ImmSel);
		checkBit("reset", "LrSel", LrSys, LrSel);
		checkPcSel("reset", Pc1, PcSel);
		checkBit("reset", "CFlag", 1'b0, CFlag);
		nReset = 1'b1;
		foreach (testName[i]) begin
			flags = testFlags[i];
			runInstruction({ADD, BR}, 0);
			checkCount(testName[i], "ADD period", 5, period);
			checkBit(testName[i], "CFlag after ADD", testFlags[i][flagC], CFlag);
			flags = ~testFlags[i]; // Seen only if the test instruction loads flags
			runInstruction(testCode[i], testWaits[i]);
			checkCount(testName[i], "period", expPeriod[i], period);
			checkCount(testName[i], "IrWe pulses", 1, irWeCount);
			checkPcSel(testName[i], expPcSel[i], seenPcSel);
			checkBit(testName[i], "RegWe in last cycle", expRegWe[i], lastRegWe);
			checkBit(testName[i], "RegWe before last cycle", 1'b0, earlyRegWe);
			if (lastRegWe)
				checkBit(testName[i], "WdSel WdSys", testCode[i][7:3] == LDW, lastWdSys);
			checkBit(testName[i], "LrWe", testCode[i] == {BRANCH, BWL}, seenLrWe);
			if (seenLrWe)
				checkBit(testName[i], "LrSel", LrPc, seenLrSel);
			checkBit(testName[i], "LrEn", testCode[i] == {BRANCH, RET}, seenLrEn);
			checkBit(testName[i], "CFlag",
				testCode[i][7:3] <= ASR ? ~testFlags[i][flagC] : testFlags[i][flagC],
				CFlag); // ALU group reloads the flags
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
